//--- core_pkg.sv
package core_pkg;

	localparam int COMMIT_RING_WIDTH = 4;
	localparam int RESULT_DEPTH = 16;
	localparam int IO_DEPTH = 4;
	localparam int NUM_GPR = 16;

	typedef logic [15:0] data_t;
	typedef logic [3:0] reg_idx_t;

	// unlisted encodings decode as nop.
	typedef enum logic [3:0] {
		ADD  = 4'h0,
		SUB  = 4'h1,
		AND  = 4'h2,
		XOR  = 4'h3,
		ADDI = 4'h4,
		IN   = 4'h5, // input word to rd.
		OUT  = 4'h6, // emits register rs1.
		NOP  = 4'h7
	} opcode_t;

	typedef struct packed {
		opcode_t opcode;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2_imm; // rs2, or zero-extended immediate for addi.
	} inst_t;

	typedef enum logic [1:0] {
		COMMIT_NULL   = 2'd0,
		COMMIT_GPR    = 2'd1,
		COMMIT_GPR_IN = 2'd2,
		COMMIT_OUT    = 2'd3
	} commit_kind_t;

	typedef struct packed {
		opcode_t opcode;
		data_t a;
		data_t b;
		reg_idx_t rd;
	} alu_op_t;

	typedef struct packed {
		reg_idx_t rd;
		data_t value;
	} gpr_result_t;

endpackage

//--- req_if.sv
`timescale 1ns/10ps

interface req_if;
	logic valid;
	logic ready;

	modport source (
		output valid,
		input ready
	);

	modport sink (
		input valid,
		output ready
	);
endinterface

//--- fifo_queue.sv
`timescale 1ns/10ps

module fifo_queue #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic push,
	input payload_t push_data,
	input logic pop,
	output payload_t pop_data,
	output logic full,
	output logic empty,
	output logic [$clog2(DEPTH+1)-1:0] count
);
	payload_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign full = count == ($clog2(DEPTH+1))'(DEPTH);
	assign empty = count == '0;
	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // idle or push and pop together.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end
endmodule

//--- inst_decode.sv
`timescale 1ns/10ps

module inst_decode (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	input core_pkg::inst_t inst_word,
	output logic inst_ready,
	req_if.source issue_req,
	output core_pkg::commit_kind_t issue_type,
	output logic alu_valid,
	output core_pkg::alu_op_t alu_op,
	output logic io_rd_valid,
	output core_pkg::reg_idx_t io_rd,
	output core_pkg::reg_idx_t rd_addr_a,
	output core_pkg::reg_idx_t rd_addr_b,
	input core_pkg::data_t rd_data_a,
	input core_pkg::data_t rd_data_b,
	input logic wb_valid,
	input core_pkg::reg_idx_t wb_rd
);
	logic [core_pkg::NUM_GPR-1:0] busy;
	logic is_alu;
	logic is_imm;
	logic has_dest;
	logic hazard;
	logic issue;

	always_comb begin
		case (inst_word.opcode)
			core_pkg::ADD, core_pkg::SUB, core_pkg::AND, core_pkg::XOR, core_pkg::ADDI:
				issue_type = core_pkg::COMMIT_GPR;
			core_pkg::IN: issue_type = core_pkg::COMMIT_GPR_IN;
			core_pkg::OUT: issue_type = core_pkg::COMMIT_OUT;
			default: issue_type = core_pkg::COMMIT_NULL;
		endcase
	end

	assign is_alu = issue_type == core_pkg::COMMIT_GPR;
	assign is_imm = inst_word.opcode == core_pkg::ADDI;
	assign has_dest = is_alu || issue_type == core_pkg::COMMIT_GPR_IN;

	assign rd_addr_a = inst_word.rs1;
	assign rd_addr_b = inst_word.rs2_imm;

	// one busy bit per register, so a second writer waits too.
	assign hazard = (is_alu && (busy[inst_word.rs1] || (!is_imm && busy[inst_word.rs2_imm]))) ||
	                (has_dest && busy[inst_word.rd]);

	assign issue_req.valid = inst_valid && issue_type != core_pkg::COMMIT_NULL && !hazard;
	assign inst_ready = issue_type == core_pkg::COMMIT_NULL || (issue_req.ready && !hazard);
	assign issue = issue_req.valid && issue_req.ready;

	assign alu_valid = issue && is_alu;
	assign alu_op.opcode = inst_word.opcode;
	assign alu_op.a = rd_data_a;
	assign alu_op.b = is_imm ? core_pkg::data_t'(inst_word.rs2_imm) : rd_data_b;
	assign alu_op.rd = inst_word.rd;

	assign io_rd_valid = issue && !is_alu;
	assign io_rd = (issue_type == core_pkg::COMMIT_OUT) ? inst_word.rs1 : inst_word.rd;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
		end else begin
			if (wb_valid) begin
				busy[wb_rd] <= 1'b0;
			end
			if (issue && has_dest) begin
				busy[inst_word.rd] <= 1'b1; // set wins over clear.
			end
		end
	end
endmodule

//--- alu_execute.sv
`timescale 1ns/10ps

module alu_execute (
	input logic clk,
	input logic reset,
	input logic alu_valid,
	input core_pkg::alu_op_t alu_op,
	output logic res_valid,
	input logic res_ready,
	output core_pkg::gpr_result_t res_data
);
	logic s1_valid;
	core_pkg::alu_op_t s1_op;
	core_pkg::data_t value;
	core_pkg::gpr_result_t s2_result;
	logic res_empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= alu_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (alu_valid) begin
			s1_op <= alu_op;
		end
	end

	always_comb begin
		case (s1_op.opcode)
			core_pkg::SUB: value = s1_op.a - s1_op.b;
			core_pkg::AND: value = s1_op.a & s1_op.b;
			core_pkg::XOR: value = s1_op.a ^ s1_op.b;
			default: value = s1_op.a + s1_op.b; // add and addi.
		endcase
	end

	assign s2_result.rd = s1_op.rd;
	assign s2_result.value = value;

	// deep enough for every alu op the ring can hold.
	fifo_queue #(
		.payload_t(core_pkg::gpr_result_t),
		.DEPTH(core_pkg::RESULT_DEPTH)
	) u_result_q (
		.clk(clk),
		.reset(reset),
		.push(s1_valid),
		.push_data(s2_result),
		.pop(res_valid && res_ready),
		.pop_data(res_data),
		.full(),
		.empty(res_empty),
		.count()
	);

	assign res_valid = !res_empty;
endmodule

//--- commit_ring.sv
`timescale 1ns/10ps

module commit_ring (
	input logic clk,
	input logic reset,
	req_if.sink issue_req,
	input core_pkg::commit_kind_t issue_type,
	req_if.source commit_req_gpr,
	req_if.source commit_req_in,
	req_if.source commit_req_out,
	output logic [core_pkg::COMMIT_RING_WIDTH-1:0] in_count
);
	core_pkg::commit_kind_t entry [2**core_pkg::COMMIT_RING_WIDTH];
	logic [core_pkg::COMMIT_RING_WIDTH-1:0] issue_ptr;
	logic [core_pkg::COMMIT_RING_WIDTH-1:0] commit_ptr;
	core_pkg::commit_kind_t head;
	logic issue;
	logic commit;

	assign head = entry[commit_ptr];

	// one slot stays free to tell full from empty.
	assign issue_req.ready = core_pkg::COMMIT_RING_WIDTH'(issue_ptr + 1'b1) != commit_ptr;

	assign commit_req_gpr.valid = head == core_pkg::COMMIT_GPR;
	assign commit_req_in.valid = head == core_pkg::COMMIT_GPR_IN;
	assign commit_req_out.valid = head == core_pkg::COMMIT_OUT;

	assign issue = issue_req.valid && issue_req.ready;
	assign commit = (commit_req_gpr.valid && commit_req_gpr.ready) ||
	                (commit_req_in.valid && commit_req_in.ready) ||
	                (commit_req_out.valid && commit_req_out.ready);

	always_ff @(posedge clk) begin
		if (reset) begin
			issue_ptr <= '0;
			commit_ptr <= '0;
			entry <= '{default: core_pkg::COMMIT_NULL};
		end else begin
			if (commit) begin
				entry[commit_ptr] <= core_pkg::COMMIT_NULL;
				commit_ptr <= commit_ptr + 1'b1;
			end
			if (issue) begin
				entry[issue_ptr] <= issue_type; // head slot only while empty.
				issue_ptr <= issue_ptr + 1'b1;
			end
		end
	end

	always_comb begin
		in_count = '0;
		for (int i = 0; i < 2**core_pkg::COMMIT_RING_WIDTH; i++) begin
			if (entry[i] == core_pkg::COMMIT_GPR_IN) begin
				in_count = in_count + 1'b1;
			end
		end
	end
endmodule

//--- commit_result.sv
`timescale 1ns/10ps

module commit_result (
	input logic clk,
	input logic reset,
	req_if.sink commit_req_gpr,
	req_if.sink commit_req_in,
	req_if.sink commit_req_out,
	input logic res_valid,
	output logic res_ready,
	input core_pkg::gpr_result_t res_data,
	input logic io_rd_valid,
	input core_pkg::reg_idx_t io_rd,
	input logic [core_pkg::COMMIT_RING_WIDTH-1:0] in_count,
	input logic in_valid,
	output logic in_ready,
	input core_pkg::data_t in_data,
	output logic out_valid,
	input logic out_ready,
	output core_pkg::data_t out_data,
	output logic wb_valid,
	output core_pkg::reg_idx_t wb_rd,
	input core_pkg::reg_idx_t rd_addr_a,
	input core_pkg::reg_idx_t rd_addr_b,
	output core_pkg::data_t rd_data_a,
	output core_pkg::data_t rd_data_b
);
	core_pkg::data_t gpr [core_pkg::NUM_GPR];
	core_pkg::data_t wb_data;
	core_pkg::reg_idx_t io_head;
	core_pkg::data_t in_head;
	logic [$clog2(core_pkg::IO_DEPTH+1)-1:0] in_buf_count;
	logic in_full;
	logic in_empty;
	logic out_full;
	logic out_empty;
	logic gpr_commit;
	logic in_commit;
	logic out_commit;

	assign commit_req_gpr.ready = res_valid;
	assign commit_req_in.ready = !in_empty;
	assign commit_req_out.ready = !out_full;

	assign gpr_commit = commit_req_gpr.valid && commit_req_gpr.ready;
	assign in_commit = commit_req_in.valid && commit_req_in.ready;
	assign out_commit = commit_req_out.valid && commit_req_out.ready;
	assign res_ready = commit_req_gpr.valid;

	// rd of IN, rs1 of OUT, in program order.
	fifo_queue #(
		.payload_t(core_pkg::reg_idx_t),
		.DEPTH(2**core_pkg::COMMIT_RING_WIDTH)
	) u_io_rd_q (
		.clk(clk),
		.reset(reset),
		.push(io_rd_valid),
		.push_data(io_rd),
		.pop(in_commit || out_commit),
		.pop_data(io_head),
		.full(),
		.empty(),
		.count()
	);

	// prefetch only as many words as IN entries are pending.
	assign in_ready = !in_full &&
	                  core_pkg::COMMIT_RING_WIDTH'(in_buf_count) < in_count;

	fifo_queue #(
		.payload_t(core_pkg::data_t),
		.DEPTH(core_pkg::IO_DEPTH)
	) u_in_q (
		.clk(clk),
		.reset(reset),
		.push(in_valid && in_ready),
		.push_data(in_data),
		.pop(in_commit),
		.pop_data(in_head),
		.full(in_full),
		.empty(in_empty),
		.count(in_buf_count)
	);

	fifo_queue #(
		.payload_t(core_pkg::data_t),
		.DEPTH(core_pkg::IO_DEPTH)
	) u_out_q (
		.clk(clk),
		.reset(reset),
		.push(out_commit),
		.push_data(gpr[io_head]),
		.pop(out_valid && out_ready),
		.pop_data(out_data),
		.full(out_full),
		.empty(out_empty),
		.count()
	);

	assign out_valid = !out_empty;

	assign wb_valid = gpr_commit || in_commit;
	assign wb_rd = gpr_commit ? res_data.rd : io_head;
	assign wb_data = gpr_commit ? res_data.value : in_head;

	always_ff @(posedge clk) begin
		if (reset) begin
			gpr <= '{default: '0};
		end else if (wb_valid) begin
			gpr[wb_rd] <= wb_data;
		end
	end

	assign rd_data_a = gpr[rd_addr_a];
	assign rd_data_b = gpr[rd_addr_b];
endmodule

//--- core_top.sv
`timescale 1ns/10ps

module core_top (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	output logic inst_ready,
	input core_pkg::inst_t inst_word,
	input logic in_valid,
	output logic in_ready,
	input core_pkg::data_t in_data,
	output logic out_valid,
	input logic out_ready,
	output core_pkg::data_t out_data
);
	req_if issue_req();
	req_if commit_req_gpr();
	req_if commit_req_in();
	req_if commit_req_out();

	core_pkg::commit_kind_t issue_type;
	logic alu_valid;
	core_pkg::alu_op_t alu_op;
	logic io_rd_valid;
	core_pkg::reg_idx_t io_rd;
	core_pkg::reg_idx_t rd_addr_a;
	core_pkg::reg_idx_t rd_addr_b;
	core_pkg::data_t rd_data_a;
	core_pkg::data_t rd_data_b;
	logic wb_valid;
	core_pkg::reg_idx_t wb_rd;
	logic res_valid;
	logic res_ready;
	core_pkg::gpr_result_t res_data;
	logic [core_pkg::COMMIT_RING_WIDTH-1:0] in_count;

	inst_decode u_decode (
		.clk(clk),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst_word(inst_word),
		.inst_ready(inst_ready),
		.issue_req(issue_req),
		.issue_type(issue_type),
		.alu_valid(alu_valid),
		.alu_op(alu_op),
		.io_rd_valid(io_rd_valid),
		.io_rd(io_rd),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd)
	);

	alu_execute u_execute (
		.clk(clk),
		.reset(reset),
		.alu_valid(alu_valid),
		.alu_op(alu_op),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_data(res_data)
	);

	commit_ring u_ring (
		.clk(clk),
		.reset(reset),
		.issue_req(issue_req),
		.issue_type(issue_type),
		.commit_req_gpr(commit_req_gpr),
		.commit_req_in(commit_req_in),
		.commit_req_out(commit_req_out),
		.in_count(in_count)
	);

	commit_result u_result (
		.clk(clk),
		.reset(reset),
		.commit_req_gpr(commit_req_gpr),
		.commit_req_in(commit_req_in),
		.commit_req_out(commit_req_out),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_data(res_data),
		.io_rd_valid(io_rd_valid),
		.io_rd(io_rd),
		.in_count(in_count),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(in_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b)
	);
endmodule

//--- tb_core.sv
`timescale 1ns/10ps

module tb_core;
	localparam int NUM_ROWS = 5;
	localparam int MAX_INST = 8;
	localparam int MAX_IO = 4;
	localparam int RESET_CYCLES = 16;
	localparam int ROW_CYCLES = 64;
	localparam int DRAIN_CYCLES = 8;
	localparam int CYCLE_LIMIT = NUM_ROWS * (ROW_CYCLES + RESET_CYCLES + DRAIN_CYCLES);

	logic clk;
	logic reset;
	logic inst_valid;
	logic inst_ready;
	core_pkg::inst_t inst_word;
	logic in_valid;
	logic in_ready;
	core_pkg::data_t in_data;
	logic out_valid;
	logic out_ready;
	core_pkg::data_t out_data;

	string test_name [NUM_ROWS];
	core_pkg::inst_t prog [NUM_ROWS][MAX_INST];
	int n_inst [NUM_ROWS];
	core_pkg::data_t in_words [NUM_ROWS][MAX_IO];
	int n_in [NUM_ROWS];
	core_pkg::data_t exp_out [NUM_ROWS][MAX_IO];
	int n_out [NUM_ROWS];

	logic [15:0] lfsr;
	int cycle_count;
	int errors;
	int rows_failed;

	core_top dut (
		.clk(clk),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.inst_word(inst_word),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(in_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
			$display("tests failed");
			$finish;
		end
	end

	// taps 16, 14, 13, 11.
	function automatic logic [15:0] lfsr_step(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bit(output logic b);
		lfsr = lfsr_step(lfsr);
		b = lfsr[0];
	endtask

	function automatic core_pkg::inst_t encode_inst(core_pkg::opcode_t op, int rd, int rs1,
			int rs2);
		core_pkg::inst_t i;
		i.opcode = op;
		i.rd = core_pkg::reg_idx_t'(rd);
		i.rs1 = core_pkg::reg_idx_t'(rs1);
		i.rs2_imm = core_pkg::reg_idx_t'(rs2);
		return i;
	endfunction

	task automatic check_data(string name, core_pkg::data_t expected, core_pkg::data_t actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_count(string name, string what, int expected, int actual);
		if (expected != actual) begin
			$display("FAIL %s %s expected %0d actual %0d", name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_flag(string name, string what, logic expected, logic actual);
		if (expected !== actual) begin
			$display("FAIL %s %s expected %b actual %b", name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		inst_valid = 1'b0;
		inst_word = '0;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
	endtask

	// expected outputs assume all registers start at zero.
	task automatic load_table();
		test_name[0] = "alu_ops";
		prog[0] = '{encode_inst(core_pkg::ADDI, 1, 0, 15), encode_inst(core_pkg::ADDI, 2, 0, 3),
			encode_inst(core_pkg::SUB, 4, 2, 1), encode_inst(core_pkg::ADD, 3, 4, 1),
			encode_inst(core_pkg::XOR, 5, 4, 2), encode_inst(core_pkg::OUT, 0, 4, 0),
			encode_inst(core_pkg::OUT, 0, 3, 0), encode_inst(core_pkg::OUT, 0, 5, 0)};
		n_inst[0] = 8;
		n_in[0] = 0;
		exp_out[0] = '{16'hfff4, 16'h0003, 16'hfff7, 16'h0000}; // 3 - 15 wraps.
		n_out[0] = 3;

		test_name[1] = "dependencies";
		prog[1] = '{encode_inst(core_pkg::ADDI, 1, 0, 5), encode_inst(core_pkg::ADD, 1, 1, 1),
			encode_inst(core_pkg::ADD, 1, 1, 1), encode_inst(core_pkg::ADDI, 2, 1, 7),
			encode_inst(core_pkg::AND, 3, 2, 1), encode_inst(core_pkg::XOR, 4, 3, 2),
			encode_inst(core_pkg::OUT, 0, 3, 0), encode_inst(core_pkg::OUT, 0, 4, 0)};
		n_inst[1] = 8;
		n_in[1] = 0;
		exp_out[1] = '{16'h0010, 16'h000b, 16'h0000, 16'h0000};
		n_out[1] = 2;

		test_name[2] = "in_order";
		prog[2] = '{encode_inst(core_pkg::IN, 1, 0, 0), encode_inst(core_pkg::IN, 2, 0, 0),
			encode_inst(core_pkg::IN, 3, 0, 0), encode_inst(core_pkg::ADD, 4, 1, 2),
			encode_inst(core_pkg::OUT, 0, 3, 0), encode_inst(core_pkg::OUT, 0, 4, 0),
			encode_inst(core_pkg::OUT, 0, 1, 0), encode_inst(core_pkg::NOP, 0, 0, 0)};
		n_inst[2] = 8;
		in_words[2] = '{16'ha5a5, 16'h1234, 16'h0f0f, 16'h0000};
		n_in[2] = 3;
		exp_out[2] = '{16'h0f0f, 16'hb7d9, 16'ha5a5, 16'h0000};
		n_out[2] = 3;

		test_name[3] = "out_backpressure";
		prog[3] = '{encode_inst(core_pkg::ADDI, 1, 0, 9), encode_inst(core_pkg::ADD, 2, 1, 1),
			encode_inst(core_pkg::OUT, 0, 1, 0), encode_inst(core_pkg::OUT, 0, 2, 0),
			encode_inst(core_pkg::SUB, 3, 0, 1), encode_inst(core_pkg::OUT, 0, 3, 0),
			encode_inst(core_pkg::ADDI, 4, 3, 9), encode_inst(core_pkg::OUT, 0, 4, 0)};
		n_inst[3] = 8;
		n_in[3] = 0;
		exp_out[3] = '{16'h0009, 16'h0012, 16'hfff7, 16'h0000};
		n_out[3] = 4;

		test_name[4] = "reset_state";
		prog[4] = '{0: encode_inst(core_pkg::IN, 1, 0, 0), 1: encode_inst(core_pkg::OUT, 0, 1, 0),
			default: encode_inst(core_pkg::NOP, 0, 0, 0)};
		n_inst[4] = 2;
		in_words[4] = '{16'h7e57, 16'h0000, 16'h0000, 16'h0000};
		n_in[4] = 1;
		exp_out[4] = '{16'h7e57, 16'h0000, 16'h0000, 16'h0000};
		n_out[4] = 1;
	endtask

	task automatic run_row(int r);
		string name;
		int ip;
		int inp;
		int op;
		int extra;
		int start_errors;
		logic in_fire;
		logic in_seen;
		logic rise_check;
		logic b;
		name = test_name[r];
		ip = 0;
		inp = 0;
		op = 0;
		extra = 0;
		in_fire = 1'b0;
		in_seen = 1'b0;
		rise_check = 1'b0;
		start_errors = errors;
		apply_reset();
		#1;
		check_flag(name, "out_valid after reset", 1'b0, out_valid);
		check_flag(name, "in_ready after reset", 1'b0, in_ready);
		check_flag(name, "inst_ready after reset", 1'b1, inst_ready);
		while (op < n_out[r]) begin
			@(negedge clk);
			inst_valid = ip < n_inst[r];
			inst_word = (ip < n_inst[r]) ? prog[r][ip] : '0;
			if (!in_valid || in_fire) begin // a pending word is held.
				random_bit(b);
				in_valid = (inp < n_in[r]) && b;
				in_data = (inp < n_in[r]) ? in_words[r][inp] : '0;
			end
			random_bit(b);
			out_ready = b;
			#1;
			if (rise_check) begin
				check_flag(name, "in_ready after first IN", 1'b1, in_ready);
				rise_check = 1'b0;
			end else if (!in_seen) begin
				check_flag(name, "in_ready with no IN pending", 1'b0, in_ready);
			end
			in_fire = in_valid && in_ready;
			if (in_fire) begin
				inp++;
			end
			if (inst_valid && inst_ready) begin
				if (inst_word.opcode == core_pkg::IN && !in_seen) begin
					in_seen = 1'b1;
					rise_check = 1'b1;
				end
				ip++;
			end
			if (out_valid && out_ready) begin
				check_data(name, exp_out[r][op], out_data);
				op++;
			end
		end
		repeat (DRAIN_CYCLES) begin // catches extra outputs.
			@(negedge clk);
			inst_valid = 1'b0;
			in_valid = 1'b0;
			out_ready = 1'b1;
			#1;
			if (out_valid) begin
				extra++;
			end
		end
		check_count(name, "outputs", n_out[r], op + extra);
		check_count(name, "instructions accepted", n_inst[r], ip);
		if (errors == start_errors) begin
			$display("test %s done, no errors", name);
		end else begin
			$display("test %s done, %0d errors", name, errors - start_errors);
			rows_failed++;
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		inst_valid = 1'b0;
		inst_word = '0;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b0;
		lfsr = 16'd33;
		cycle_count = 0;
		errors = 0;
		rows_failed = 0;
		load_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		$display("%0d tests run, %0d passed, %0d failed", NUM_ROWS, NUM_ROWS - rows_failed,
			rows_failed);
		if (rows_failed == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end
endmodule

//--- src.f
core_pkg.sv
req_if.sv
fifo_queue.sv
inst_decode.sv
alu_execute.sv
commit_ring.sv
commit_result.sv
core_top.sv
tb_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = tb_core
FILELIST = src.f

SOURCES = $(shell grep -v '^+' $(FILELIST))
SIM = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

obj_dir/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee sim.log
	@grep -q "^all tests passed$$" sim.log || (echo "simulation reported failure"; exit 1)

clean:
	rm -rf obj_dir sim.log
